/* source/mrp_pkg.sv */
package mrp_pkg;

    // address and port widths of the flow key
    localparam int IP_ADDR_W  = 32;
    localparam int PORT_NUM_W = 16;

    // data beat
    localparam int DATA_W     = 64;
    localparam int PADBYTES_W = 3;

    localparam int MRP_KEY_W  = (2 * IP_ADDR_W) + (2 * PORT_NUM_W);

    // src ip, dst ip, src port, dst port from msb down
    typedef logic [MRP_KEY_W-1:0] mrp_key_t;

endpackage

/* source/mrp_rx_pkg.sv */
package mrp_rx_pkg;

    localparam int MAX_CONNS = 8;
    localparam int CONN_ID_W = $clog2(MAX_CONNS);

    // per-packet control
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        ALLOC,
        META_OUT,
        DATA,
        DROP
    } rx_state_e;

    // owner of the cam and pool write side this cycle
    typedef enum logic [1:0] {
        GRANT_NONE,
        GRANT_RX,
        GRANT_DEALLOC
    } arb_grant_e;

endpackage

/* source/conn_id_cam.sv */
`timescale 1ns/100ps

module conn_id_cam (
     input  logic                                   clk
    ,input  logic                                   rst

    ,input  logic                                   wr_val_i
    ,input  logic                                   wr_set_i
    ,input  mrp_pkg::mrp_key_t                      wr_key_i
    ,input  logic   [mrp_rx_pkg::CONN_ID_W-1:0]     wr_id_i

    ,input  mrp_pkg::mrp_key_t                      lookup_key_i
    ,output logic                                   lookup_hit_o
    ,output logic   [mrp_rx_pkg::CONN_ID_W-1:0]     lookup_id_o
);

    import mrp_pkg::*;
    import mrp_rx_pkg::*;

    // entry index is the connection id
    logic   [MAX_CONNS-1:0] entry_valid;
    mrp_key_t               entry_key [MAX_CONNS];

    always_ff @(posedge clk) begin
        if (rst) begin
            entry_valid <= '0;
        end
        else if (wr_val_i) begin
            entry_valid[wr_id_i] <= wr_set_i;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_val_i) begin
            entry_key[wr_id_i] <= wr_key_i;
        end
    end

    // keys are unique among valid entries, so at most one match
    always_comb begin
        lookup_hit_o = 1'b0;
        lookup_id_o  = '0;
        for (int i = 0; i < MAX_CONNS; i++) begin
            if (entry_valid[i] && (entry_key[i] == lookup_key_i)) begin
                lookup_hit_o = 1'b1;
                lookup_id_o  = CONN_ID_W'(i);
            end
        end
    end

endmodule

/* source/conn_id_pool.sv */
`timescale 1ns/100ps

module conn_id_pool (
     input  logic                                   clk
    ,input  logic                                   rst

    ,input  logic                                   pop_i
    ,input  logic                                   push_i
    ,input  logic   [mrp_rx_pkg::CONN_ID_W-1:0]     push_id_i

    ,output logic                                   avail_o
    ,output logic   [mrp_rx_pkg::CONN_ID_W-1:0]     free_id_o
);

    import mrp_rx_pkg::*;

    // one bit per id, set when free
    logic   [MAX_CONNS-1:0] free_map;

    always_ff @(posedge clk) begin
        if (rst) begin
            free_map <= '1;
        end
        else begin
            if (pop_i) begin
                free_map[free_id_o] <= 1'b0;
            end
            if (push_i) begin
                free_map[push_id_i] <= 1'b1;
            end
        end
    end

    assign avail_o = |free_map;

    // lowest free id wins
    always_comb begin
        free_id_o = '0;
        for (int i = MAX_CONNS - 1; i >= 0; i--) begin
            if (free_map[i]) begin
                free_id_o = CONN_ID_W'(i);
            end
        end
    end

endmodule

/* source/conn_table_arbiter.sv */
`timescale 1ns/100ps

module conn_table_arbiter (
     input  logic                                   alloc_req_i
    ,input  mrp_pkg::mrp_key_t                      alloc_key_i
    ,output logic                                   alloc_gnt_o

    ,input  logic                                   dealloc_val_i
    ,input  mrp_pkg::mrp_key_t                      dealloc_key_i
    ,input  logic   [mrp_rx_pkg::CONN_ID_W-1:0]     dealloc_conn_id_i
    ,output logic                                   dealloc_rdy_o

    ,input  logic   [mrp_rx_pkg::CONN_ID_W-1:0]     pool_id_i

    ,output logic                                   cam_wr_val_o
    ,output logic                                   cam_wr_set_o
    ,output mrp_pkg::mrp_key_t                      cam_wr_key_o
    ,output logic   [mrp_rx_pkg::CONN_ID_W-1:0]     cam_wr_id_o

    ,output logic                                   pool_pop_o
    ,output logic                                   pool_push_o
    ,output logic   [mrp_rx_pkg::CONN_ID_W-1:0]     pool_push_id_o
);

    import mrp_rx_pkg::*;

    arb_grant_e grant;

    // receive flow always goes first
    always_comb begin
        if (alloc_req_i) begin
            grant = GRANT_RX;
        end
        else if (dealloc_val_i) begin
            grant = GRANT_DEALLOC;
        end
        else begin
            grant = GRANT_NONE;
        end
    end

    assign alloc_gnt_o   = (grant == GRANT_RX);
    assign dealloc_rdy_o = ~alloc_req_i;

    // set at the pooled id, or clear at the released one
    assign cam_wr_val_o = (grant != GRANT_NONE);
    assign cam_wr_set_o = (grant == GRANT_RX);
    assign cam_wr_key_o = (grant == GRANT_RX) ? alloc_key_i : dealloc_key_i;
    assign cam_wr_id_o  = (grant == GRANT_RX) ? pool_id_i : dealloc_conn_id_i;

    assign pool_pop_o     = (grant == GRANT_RX);
    assign pool_push_o    = (grant == GRANT_DEALLOC);
    assign pool_push_id_o = dealloc_conn_id_i;

endmodule

/* source/mrp_rx_flow.sv */
`timescale 1ns/100ps

module mrp_rx_flow (
     input  logic                                   clk
    ,input  logic                                   rst

    ,input  logic                                   meta_val_i
    ,input  logic   [mrp_pkg::IP_ADDR_W-1:0]        src_ip_i
    ,input  logic   [mrp_pkg::IP_ADDR_W-1:0]        dst_ip_i
    ,input  logic   [mrp_pkg::PORT_NUM_W-1:0]       src_port_i
    ,input  logic   [mrp_pkg::PORT_NUM_W-1:0]       dst_port_i
    ,output logic                                   meta_rdy_o

    ,input  logic                                   data_val_i
    ,input  logic   [mrp_pkg::DATA_W-1:0]           data_i
    ,input  logic                                   data_last_i
    ,input  logic   [mrp_pkg::PADBYTES_W-1:0]       data_padbytes_i
    ,output logic                                   data_rdy_o

    ,output logic                                   out_meta_val_o
    ,output logic                                   out_start_o
    ,output logic   [mrp_rx_pkg::CONN_ID_W-1:0]     out_conn_id_o
    ,input  logic                                   out_meta_rdy_i

    ,output logic                                   out_val_o
    ,output logic   [mrp_pkg::DATA_W-1:0]           out_data_o
    ,output logic                                   out_last_o
    ,output logic   [mrp_pkg::PADBYTES_W-1:0]       out_padbytes_o
    ,input  logic                                   out_rdy_i

    ,output mrp_pkg::mrp_key_t                      lookup_key_o
    ,input  logic                                   lookup_hit_i
    ,input  logic   [mrp_rx_pkg::CONN_ID_W-1:0]     lookup_id_i

    ,input  logic                                   id_avail_i
    ,output logic                                   alloc_req_o
    ,output mrp_pkg::mrp_key_t                      alloc_key_o
    ,input  logic                                   alloc_gnt_i
    ,input  logic   [mrp_rx_pkg::CONN_ID_W-1:0]     alloc_id_i
);

    import mrp_pkg::*;
    import mrp_rx_pkg::*;

    rx_state_e              state;
    rx_state_e              state_next;

    mrp_key_t               key_reg;
    logic   [CONN_ID_W-1:0] conn_id_reg;
    logic                   start_reg;

    logic                   data_xfer;

    assign data_xfer = data_val_i & data_rdy_o;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end
        else begin
            state <= state_next;
        end
    end

    // key captured with the metadata beat
    always_ff @(posedge clk) begin
        if (meta_val_i && meta_rdy_o) begin
            key_reg <= {src_ip_i, dst_ip_i, src_port_i, dst_port_i};
        end
    end

    always_ff @(posedge clk) begin
        if ((state == LOOKUP) && lookup_hit_i) begin
            conn_id_reg <= lookup_id_i;
            start_reg   <= 1'b0;
        end
        else if ((state == ALLOC) && alloc_gnt_i) begin
            conn_id_reg <= alloc_id_i;
            start_reg   <= 1'b1;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (meta_val_i) begin
                    state_next = LOOKUP;
                end
            end
            LOOKUP: begin
                if (lookup_hit_i) begin
                    state_next = META_OUT;
                end
                else if (id_avail_i) begin
                    state_next = ALLOC;
                end
                else begin
                    state_next = DROP;
                end
            end
            ALLOC: begin
                if (alloc_gnt_i) begin
                    state_next = META_OUT;
                end
            end
            META_OUT: begin
                if (out_meta_rdy_i) begin
                    state_next = DATA;
                end
            end
            DATA, DROP: begin
                if (data_xfer && data_last_i) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    assign meta_rdy_o   = (state == IDLE);
    assign lookup_key_o = key_reg;
    assign alloc_key_o  = key_reg;
    assign alloc_req_o  = (state == ALLOC);

    assign out_meta_val_o = (state == META_OUT);
    assign out_start_o    = start_reg;
    assign out_conn_id_o  = conn_id_reg;

    // pass-through in DATA, sink everything in DROP
    assign out_val_o  = (state == DATA) & data_val_i;
    assign data_rdy_o = ((state == DATA) & out_rdy_i) | (state == DROP);

    assign out_data_o     = data_i;
    assign out_last_o     = data_last_i;
    assign out_padbytes_o = data_padbytes_i;

endmodule

/* source/mrp_rx.sv */
`timescale 1ns/100ps

module mrp_rx (
     input  logic                                   clk
    ,input  logic                                   rst

    ,input  logic                                   meta_val_i
    ,input  logic   [mrp_pkg::IP_ADDR_W-1:0]        src_ip_i
    ,input  logic   [mrp_pkg::IP_ADDR_W-1:0]        dst_ip_i
    ,input  logic   [mrp_pkg::PORT_NUM_W-1:0]       src_port_i
    ,input  logic   [mrp_pkg::PORT_NUM_W-1:0]       dst_port_i
    ,output logic                                   meta_rdy_o

    ,input  logic                                   data_val_i
    ,input  logic   [mrp_pkg::DATA_W-1:0]           data_i
    ,input  logic                                   data_last_i
    ,input  logic   [mrp_pkg::PADBYTES_W-1:0]       data_padbytes_i
    ,output logic                                   data_rdy_o

    ,output logic                                   out_meta_val_o
    ,output logic                                   out_start_o
    ,output logic   [mrp_rx_pkg::CONN_ID_W-1:0]     out_conn_id_o
    ,input  logic                                   out_meta_rdy_i

    ,output logic                                   out_val_o
    ,output logic   [mrp_pkg::DATA_W-1:0]           out_data_o
    ,output logic                                   out_last_o
    ,output logic   [mrp_pkg::PADBYTES_W-1:0]       out_padbytes_o
    ,input  logic                                   out_rdy_i

    ,input  logic                                   dealloc_val_i
    ,input  mrp_pkg::mrp_key_t                      dealloc_key_i
    ,input  logic   [mrp_rx_pkg::CONN_ID_W-1:0]     dealloc_conn_id_i
    ,output logic                                   dealloc_rdy_o
);

    import mrp_pkg::*;
    import mrp_rx_pkg::*;

    mrp_key_t               lookup_key;
    logic                   lookup_hit;
    logic   [CONN_ID_W-1:0] lookup_id;

    logic                   alloc_req;
    mrp_key_t               alloc_key;
    logic                   alloc_gnt;

    logic                   id_avail;
    logic   [CONN_ID_W-1:0] free_id;

    // shared write side of cam and pool
    logic                   cam_wr_val;
    logic                   cam_wr_set;
    mrp_key_t               cam_wr_key;
    logic   [CONN_ID_W-1:0] cam_wr_id;
    logic                   pool_pop;
    logic                   pool_push;
    logic   [CONN_ID_W-1:0] pool_push_id;

    mrp_rx_flow u_flow (
         .clk               (clk                )
        ,.rst               (rst                )
        ,.meta_val_i        (meta_val_i         )
        ,.src_ip_i          (src_ip_i           )
        ,.dst_ip_i          (dst_ip_i           )
        ,.src_port_i        (src_port_i         )
        ,.dst_port_i        (dst_port_i         )
        ,.meta_rdy_o        (meta_rdy_o         )
        ,.data_val_i        (data_val_i         )
        ,.data_i            (data_i             )
        ,.data_last_i       (data_last_i        )
        ,.data_padbytes_i   (data_padbytes_i    )
        ,.data_rdy_o        (data_rdy_o         )
        ,.out_meta_val_o    (out_meta_val_o     )
        ,.out_start_o       (out_start_o        )
        ,.out_conn_id_o     (out_conn_id_o      )
        ,.out_meta_rdy_i    (out_meta_rdy_i     )
        ,.out_val_o         (out_val_o          )
        ,.out_data_o        (out_data_o         )
        ,.out_last_o        (out_last_o         )
        ,.out_padbytes_o    (out_padbytes_o     )
        ,.out_rdy_i         (out_rdy_i          )
        ,.lookup_key_o      (lookup_key         )
        ,.lookup_hit_i      (lookup_hit         )
        ,.lookup_id_i       (lookup_id          )
        ,.id_avail_i        (id_avail           )
        ,.alloc_req_o       (alloc_req          )
        ,.alloc_key_o       (alloc_key          )
        ,.alloc_gnt_i       (alloc_gnt          )
        ,.alloc_id_i        (free_id            )
    );

    conn_table_arbiter u_arbiter (
         .alloc_req_i       (alloc_req          )
        ,.alloc_key_i       (alloc_key          )
        ,.alloc_gnt_o       (alloc_gnt          )
        ,.dealloc_val_i     (dealloc_val_i      )
        ,.dealloc_key_i     (dealloc_key_i      )
        ,.dealloc_conn_id_i (dealloc_conn_id_i  )
        ,.dealloc_rdy_o     (dealloc_rdy_o      )
        ,.pool_id_i         (free_id            )
        ,.cam_wr_val_o      (cam_wr_val         )
        ,.cam_wr_set_o      (cam_wr_set         )
        ,.cam_wr_key_o      (cam_wr_key         )
        ,.cam_wr_id_o       (cam_wr_id          )
        ,.pool_pop_o        (pool_pop           )
        ,.pool_push_o       (pool_push          )
        ,.pool_push_id_o    (pool_push_id       )
    );

    conn_id_cam u_cam (
         .clk               (clk                )
        ,.rst               (rst                )
        ,.wr_val_i          (cam_wr_val         )
        ,.wr_set_i          (cam_wr_set         )
        ,.wr_key_i          (cam_wr_key         )
        ,.wr_id_i           (cam_wr_id          )
        ,.lookup_key_i      (lookup_key         )
        ,.lookup_hit_o      (lookup_hit         )
        ,.lookup_id_o       (lookup_id          )
    );

    conn_id_pool u_pool (
         .clk               (clk                )
        ,.rst               (rst                )
        ,.pop_i             (pool_pop           )
        ,.push_i            (pool_push          )
        ,.push_id_i         (pool_push_id       )
        ,.avail_o           (id_avail           )
        ,.free_id_o         (free_id            )
    );

endmodule

/* testbench/mrp_rx_model.svh */
`ifndef MRP_RX_MODEL_SVH
`define MRP_RX_MODEL_SVH

// expected connection table, index is the connection id
mrp_key_t           tbl_key [MAX_CONNS];
logic [MAX_CONNS-1:0] tbl_valid = '0;

logic [15:0]        lfsr = 16'd55167;

// x^16 + x^14 + x^13 + x^11
function automatic logic lfsr_step();
    logic fb;
    fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
endfunction

function automatic mrp_key_t rand_bits(input int n);
    mrp_key_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[MRP_KEY_W-2:0], lfsr_step()};
    end
    return v;
endfunction

function automatic int rand_int(input int n);
    return int'(rand_bits(n));
endfunction

function automatic void release_conn(input logic [CONN_ID_W-1:0] id);
    tbl_valid[id] = 1'b0;
endfunction

// lookup sees the table before a release in the same cycle,
// a new id is taken after it; returns 1 on a drop
function automatic logic expected_conn(input mrp_key_t key, input logic rel_val,
                                       input logic [CONN_ID_W-1:0] rel_id,
                                       output logic [CONN_ID_W-1:0] id,
                                       output logic start);
    logic hit;
    logic any_free;
    logic found;
    hit      = 1'b0;
    any_free = 1'b0;
    found    = 1'b0;
    id       = '0;
    start    = 1'b0;
    for (int i = 0; i < MAX_CONNS; i++) begin
        if (tbl_valid[i] && (tbl_key[i] == key)) begin
            hit = 1'b1;
            id  = CONN_ID_W'(i);
        end
        if (!tbl_valid[i]) begin
            any_free = 1'b1;
        end
    end
    if (rel_val) begin
        release_conn(rel_id);
    end
    if (hit) begin
        return 1'b0;
    end
    if (!any_free) begin
        return 1'b1;
    end
    for (int i = 0; i < MAX_CONNS; i++) begin
        if (!found && !tbl_valid[i]) begin
            found = 1'b1;
            id    = CONN_ID_W'(i);
        end
    end
    tbl_valid[id] = 1'b1;
    tbl_key[id]   = key;
    start         = 1'b1;
    return 1'b0;
endfunction

`endif

/* testbench/mrp_rx_tb.sv */
`timescale 1ns/100ps

module mrp_rx_tb;

    import mrp_pkg::*;
    import mrp_rx_pkg::*;

    `include "mrp_rx_model.svh"

    localparam int BEAT_W   = DATA_W + 1 + PADBYTES_W;
    localparam int NUM_KEYS = 12;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   meta_val_i;
    logic [IP_ADDR_W-1:0]   src_ip_i;
    logic [IP_ADDR_W-1:0]   dst_ip_i;
    logic [PORT_NUM_W-1:0]  src_port_i;
    logic [PORT_NUM_W-1:0]  dst_port_i;
    logic                   meta_rdy_o;
    logic                   data_val_i;
    logic [DATA_W-1:0]      data_i;
    logic                   data_last_i;
    logic [PADBYTES_W-1:0]  data_padbytes_i;
    logic                   data_rdy_o;
    logic                   out_meta_val_o;
    logic                   out_start_o;
    logic [CONN_ID_W-1:0]   out_conn_id_o;
    logic                   out_meta_rdy_i;
    logic                   out_val_o;
    logic [DATA_W-1:0]      out_data_o;
    logic                   out_last_o;
    logic [PADBYTES_W-1:0]  out_padbytes_o;
    logic                   out_rdy_i;
    logic                   dealloc_val_i;
    mrp_key_t               dealloc_key_i;
    logic [CONN_ID_W-1:0]   dealloc_conn_id_i;
    logic                   dealloc_rdy_o;

    string                  test_name = "reset";
    int                     value_errors = 0;
    int                     xfer_errors = 0;
    int                     beats_sent = 0;
    int                     cycle_count = 0;
    logic                   random_ready = 1'b0;
    logic                   random_done = 1'b0;

    mrp_key_t               key_pool [NUM_KEYS];
    logic [BEAT_W-1:0]      pkt_beats [$];
    logic [BEAT_W-1:0]      exp_beats [$];
    logic [CONN_ID_W:0]     exp_meta [$];
    logic [BEAT_W-1:0]      beat_exp;
    logic [CONN_ID_W:0]     meta_exp;

    logic                   lookup_pending = 1'b0;
    int                     meta_wait = 0;
    mrp_key_t               pending_key;
    logic                   rel_val;
    logic                   drop;
    logic [CONN_ID_W-1:0]   exp_id;
    logic                   exp_start;
    logic [CONN_ID_W-1:0]   pick;

    mrp_rx u_dut (.*);

    always #2 clk = ~clk;

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (exp !== act) begin
            $display("[FAIL] %s %s: expected %0b, got %0b", test_name, what, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_meta(input logic [CONN_ID_W-1:0] exp_cid, input logic exp_st,
                              input logic [CONN_ID_W-1:0] act_cid, input logic act_st);
        if ((exp_cid !== act_cid) || (exp_st !== act_st)) begin
            $display("[FAIL] %s meta: expected id %0d start %0b, got id %0d start %0b",
                     test_name, exp_cid, exp_st, act_cid, act_st);
            value_errors++;
        end
    endtask

    task automatic check_beat(input logic [DATA_W-1:0] exp_data, input logic exp_last,
                              input logic [PADBYTES_W-1:0] exp_pad,
                              input logic [DATA_W-1:0] act_data, input logic act_last,
                              input logic [PADBYTES_W-1:0] act_pad);
        if ((exp_data !== act_data) || (exp_last !== act_last) || (exp_pad !== act_pad)) begin
            $display("[FAIL] %s beat: expected %h last %0b pad %0d, got %h last %0b pad %0d",
                     test_name, exp_data, exp_last, exp_pad, act_data, act_last, act_pad);
            value_errors++;
        end
    endtask

    task automatic send_packet(input mrp_key_t key, input int nbeats);
        logic                   last;
        logic [PADBYTES_W-1:0]  pad;
        pkt_beats.delete();
        for (int i = 0; i < nbeats; i++) begin
            last = (i == nbeats - 1);
            pad  = '0;
            if (last) begin
                pad = PADBYTES_W'(rand_bits(PADBYTES_W));
            end
            pkt_beats.push_back({DATA_W'(rand_bits(DATA_W)), last, pad});
        end
        beats_sent += nbeats;
        {src_ip_i, dst_ip_i, src_port_i, dst_port_i} = key;
        meta_val_i = 1'b1;
        do @(negedge clk); while (!meta_rdy_o);
        @(posedge clk);
        #1;
        meta_val_i = 1'b0;
        foreach (pkt_beats[i]) begin
            data_val_i = 1'b1;
            {data_i, data_last_i, data_padbytes_i} = pkt_beats[i];
            do @(negedge clk); while (!data_rdy_o);
            @(posedge clk);
            #1;
        end
        data_val_i = 1'b0;
    endtask

    task automatic send_dealloc(input logic [CONN_ID_W-1:0] id);
        dealloc_val_i     = 1'b1;
        dealloc_conn_id_i = id;
        dealloc_key_i     = tbl_key[id];
        do @(negedge clk); while (!dealloc_rdy_o);
        @(posedge clk);
        #1;
        dealloc_val_i = 1'b0;
    endtask

    // back-pressure on both output channels
    initial begin
        out_meta_rdy_i = 1'b1;
        out_rdy_i      = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            out_meta_rdy_i = !random_ready || (rand_int(2) != 0);
            out_rdy_i      = !random_ready || (rand_int(2) != 0);
        end
    end

    // model follows the DUT handshakes, values settled by the falling edge
    always @(negedge clk) begin
        if (rst) begin
            lookup_pending = 1'b0;
            meta_wait      = 0;
        end
        else begin
            rel_val = dealloc_val_i && dealloc_rdy_o;
            // output metadata due one cycle after lookup on a hit, two on an allocation
            if (meta_wait > 0) begin
                meta_wait--;
                check_flag("out_meta_val_o latency", (meta_wait == 0), out_meta_val_o);
            end
            if (lookup_pending) begin
                drop = expected_conn(pending_key, rel_val, dealloc_conn_id_i, exp_id, exp_start);
                if (!drop) begin
                    meta_wait = exp_start ? 2 : 1;
                    exp_meta.push_back({exp_start, exp_id});
                    foreach (pkt_beats[i]) begin
                        exp_beats.push_back(pkt_beats[i]);
                    end
                end
            end
            else if (rel_val) begin
                release_conn(dealloc_conn_id_i);
            end
            lookup_pending = meta_val_i && meta_rdy_o;
            pending_key    = {src_ip_i, dst_ip_i, src_port_i, dst_port_i};
        end
    end

    always @(negedge clk) begin
        if (!rst && out_meta_val_o && out_meta_rdy_i) begin
            if (exp_meta.size() == 0) begin
                $display("%s: output metadata appeared that no packet should give", test_name);
                xfer_errors++;
            end
            else begin
                meta_exp = exp_meta.pop_front();
                check_meta(meta_exp[CONN_ID_W-1:0], meta_exp[CONN_ID_W],
                           out_conn_id_o, out_start_o);
            end
        end
        if (!rst && out_val_o && out_rdy_i) begin
            if (exp_beats.size() == 0) begin
                $display("%s: output data beat appeared that no packet should give", test_name);
                xfer_errors++;
            end
            else begin
                beat_exp = exp_beats.pop_front();
                check_beat(beat_exp[BEAT_W-1 -: DATA_W], beat_exp[PADBYTES_W],
                           beat_exp[PADBYTES_W-1:0], out_data_o, out_last_o, out_padbytes_o);
            end
        end
    end

    // limit grows with the beats handed to the DUT
    initial begin
        while (cycle_count <= beats_sent * 20 + 1000) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("watchdog: run stuck after %0d cycles", cycle_count);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        rst               = 1'b1;
        meta_val_i        = 1'b0;
        src_ip_i          = '0;
        dst_ip_i          = '0;
        src_port_i        = '0;
        dst_port_i        = '0;
        data_val_i        = 1'b0;
        data_i            = '0;
        data_last_i       = 1'b0;
        data_padbytes_i   = '0;
        dealloc_val_i     = 1'b0;
        dealloc_key_i     = '0;
        dealloc_conn_id_i = '0;
        for (int i = 0; i < NUM_KEYS; i++) begin
            key_pool[i] = rand_bits(MRP_KEY_W);
        end
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_flag("out_meta_val_o", 1'b0, out_meta_val_o);
        check_flag("out_val_o", 1'b0, out_val_o);
        check_flag("data_rdy_o", 1'b0, data_rdy_o);
        check_flag("meta_rdy_o", 1'b1, meta_rdy_o);
        check_flag("dealloc_rdy_o", 1'b1, dealloc_rdy_o);
        @(posedge clk);
        #1;

        test_name = "new_key";
        send_packet(key_pool[0], 3);
        test_name = "known_key";
        send_packet(key_pool[0], 2);
        test_name = "fill_table";
        for (int i = 1; i < MAX_CONNS; i++) begin
            send_packet(key_pool[i], 1 + rand_int(2));
        end
        test_name = "drop_when_full";
        send_packet(key_pool[MAX_CONNS], 4);

        // ids 3 and 5 go back, key 3 must come back as new
        test_name = "dealloc";
        send_dealloc(CONN_ID_W'(3));
        send_dealloc(CONN_ID_W'(5));
        send_packet(key_pool[MAX_CONNS + 1], 2);
        send_packet(key_pool[3], 2);

        test_name    = "random";
        random_ready = 1'b1;
        fork
            begin
                for (int n = 0; n < 200; n++) begin
                    send_packet(key_pool[rand_int(4) % NUM_KEYS], 1 + rand_int(3));
                end
                random_done = 1'b1;
            end
            begin
                while (!random_done) begin
                    @(posedge clk);
                    #1;
                    if (rand_int(3) == 0) begin
                        pick = CONN_ID_W'(rand_bits(CONN_ID_W));
                        if (tbl_valid[pick]) begin
                            send_dealloc(pick);
                        end
                    end
                end
            end
        join
        random_ready = 1'b0;
        repeat (10) @(posedge clk);

        if ((exp_meta.size() != 0) || (exp_beats.size() != 0)) begin
            $display("missing output: %0d metadata and %0d data beats never came out",
                     exp_meta.size(), exp_beats.size());
            xfer_errors++;
        end
        $display("value errors: %0d, transfer errors: %0d", value_errors, xfer_errors);
        if ((value_errors + xfer_errors) == 0) begin
            $display("Done: no errors");
        end
        else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+testbench
source/mrp_pkg.sv
source/mrp_rx_pkg.sv
source/conn_id_cam.sv
source/conn_id_pool.sv
source/conn_table_arbiter.sv
source/mrp_rx_flow.sv
source/mrp_rx.sv
testbench/mrp_rx_tb.sv

/* Makefile */
VERILATOR  ?= verilator
FILELIST   ?= project.f
TB_TOP     ?= mrp_rx_tb
RTL_TOP    ?= mrp_rx
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing -j 0
PASS_MSG   ?= Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
